/* verilog/board_pkg.sv */
// Shared constants and types for the GPIO board wrapper.
// The RTL and the testbench refer to everything here by scoped name.
// Command bytes use the layout {op[1:0], reserved[1:0], data[3:0]}.

package board_pkg;

  //////////////////////////////
  // Sizes and timing
  //////////////////////////////

  localparam int unsigned GPIO_COUNT      = 4;
  localparam int unsigned CLKS_PER_BIT    = 16;
  localparam logic [15:0] RTC_DIV_LAST    = 16'd610;
  localparam int unsigned PWM_PERIOD_BITS = 4;

  // UART bit timer
  localparam int unsigned            RX_CNT_BITS  = $clog2(CLKS_PER_BIT);
  localparam logic [RX_CNT_BITS-1:0] RX_BIT_LAST  = RX_CNT_BITS'(CLKS_PER_BIT - 1);
  localparam logic [RX_CNT_BITS-1:0] RX_HALF_LAST = RX_CNT_BITS'(CLKS_PER_BIT / 2 - 1);

  // UART receiver states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  // Command opcodes
  localparam logic [1:0] OP_WR_OUT     = 2'd0;
  localparam logic [1:0] OP_WR_EN      = 2'd1;
  localparam logic [1:0] OP_SET_STATUS = 2'd2;
  localparam logic [1:0] OP_LATCH_IN   = 2'd3;

  // GPIO output values and enables
  typedef struct packed {
    logic [GPIO_COUNT-1:0] out;
    logic [GPIO_COUNT-1:0] out_en;
  } gpio_pads_t;

  // One received byte, either raw or split into command fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [1:0] op;
      logic [1:0] rsvd;
      logic [3:0] data;
    } fields;
  } gpio_cmd_u;

endpackage

/* verilog/rst_sync.sv */
// Reset synchronizer for the internal system reset.
// Asserts as soon as rst_n drops and releases on the second
// soc_clk rising edge after rst_n rises.

`timescale 1ns/1ps

module rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rst_no
);

  logic [1:0] sync_q;

  // Ones shift in from the bottom after release
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

/* verilog/rtc_divider.sv */
// Slow reference clock for the board, divided down from soc_clk.
// The output toggles once every RTC_DIV_LAST + 1 cycles and gives
// a square wave. It starts low out of reset.

`timescale 1ns/1ps

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o
);

  logic [15:0] cnt_q;
  logic        rtc_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == board_pkg::RTC_DIV_LAST) begin
      // Half period done
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 16'd1;
    end
  end

  assign rtc_clk_o = rtc_q;

endmodule

/* verilog/fan_pwm.sv */
// Fan PWM generator with a fixed 16 cycle period.
// The three fan switches set the duty to 2*sw out of 16 cycles.
// Setting 0 turns the fan off. The output is registered.

`timescale 1ns/1ps

module fan_pwm (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [2:0] fan_sw_i,
  output logic       fan_pwm_o
);

  logic [board_pkg::PWM_PERIOD_BITS-1:0] cnt_q;
  logic [board_pkg::PWM_PERIOD_BITS-1:0] thresh;
  logic                                  pwm_q;

  // Twice the switch setting
  assign thresh = {fan_sw_i, 1'b0};

  // Free-running period counter
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (cnt_q < thresh);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

/* verilog/uart_rx.sv */
// 8N1 UART receiver for command bytes.
// A falling edge starts a frame. Every bit is sampled at its middle,
// LSB first. valid_o pulses for one cycle after a good stop bit and
// byte_o holds the byte until the next frame. A low stop bit drops
// the byte, and a start edge that is high again at mid-bit is ignored.

`timescale 1ns/1ps

module uart_rx (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       valid_o
);

  logic                               rx_meta;
  logic                               rx_sync;
  logic                               rx_prev;
  logic [1:0]                         state_q;
  logic [board_pkg::RX_CNT_BITS-1:0]  cnt_q;
  logic [2:0]                         bit_idx_q;
  logic [7:0]                         shift_q;
  logic                               valid_q;

  //////////////////////////////
  // Input sync
  //////////////////////////////

  // Line idles high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= board_pkg::RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        board_pkg::RX_IDLE: begin
          if (rx_prev && !rx_sync) begin
            state_q <= board_pkg::RX_START;
            cnt_q   <= '0;
          end
        end
        board_pkg::RX_START: begin
          if (cnt_q == board_pkg::RX_HALF_LAST) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Glitch check at mid start bit
            state_q   <= rx_sync ? board_pkg::RX_IDLE : board_pkg::RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        board_pkg::RX_DATA: begin
          if (cnt_q == board_pkg::RX_BIT_LAST) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= board_pkg::RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          if (cnt_q == board_pkg::RX_BIT_LAST) begin
            cnt_q   <= '0;
            state_q <= board_pkg::RX_IDLE;
            valid_q <= rx_sync;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // Data shift register, new bits enter at the top
  always_ff @(posedge soc_clk) begin
    if (state_q == board_pkg::RX_DATA && cnt_q == board_pkg::RX_BIT_LAST) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  assign byte_o  = shift_q;
  assign valid_o = valid_q;

endmodule

/* verilog/gpio_ctrl.sv */
// GPIO register block driven by UART command bytes.
// Holds the output values, the output enables and the status bit.
// A byte is taken on the edge after cmd_valid_i, and only while
// fetch_en_i is high. Other bytes are dropped.
// Op 3 latches the masked inputs into the output register.

`timescale 1ns/1ps

module gpio_ctrl (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic                              fetch_en_i,
  input  board_pkg::gpio_cmd_u              cmd_i,
  input  logic                              cmd_valid_i,
  input  logic [board_pkg::GPIO_COUNT-1:0]  gpio_in_i,
  output board_pkg::gpio_pads_t             pads_o,
  output logic                              status_o
);

  board_pkg::gpio_pads_t pads_q;
  logic                  status_q;
  logic                  cmd_take;

  assign cmd_take = cmd_valid_i & fetch_en_i;

  //////////////////////////////
  // Command decode
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pads_q   <= '0;
      status_q <= 1'b0;
    end else if (cmd_take) begin
      case (cmd_i.fields.op)
        board_pkg::OP_WR_OUT: begin
          pads_q.out <= cmd_i.fields.data;
        end
        board_pkg::OP_WR_EN: begin
          pads_q.out_en <= cmd_i.fields.data;
        end
        board_pkg::OP_SET_STATUS: begin
          status_q <= cmd_i.fields.data[0];
        end
        default: begin
          // Driving pins read back as 0 here
          pads_q.out <= gpio_in_i;
        end
      endcase
    end
  end

  assign pads_o   = pads_q;
  assign status_o = status_q;

endmodule

/* verilog/board_top.sv */
// Board level top for the small GPIO system.
// soc_clk enters directly and rst_n is the board reset button.
// Holds the reset synchronizer, the RTC divider, the fan PWM, the
// UART command receiver and the GPIO register block. Pads are gated
// per pin: outputs by their enable, inputs by the inverse enable.

`timescale 1ns/1ps

module board_top (
  input  logic                              soc_clk,
  input  logic                              rst_n,
  input  logic                              fetch_en_i,
  input  logic [board_pkg::GPIO_COUNT-1:0]  gpio_i,
  output logic [board_pkg::GPIO_COUNT-1:0]  gpio_o,
  output logic                              status_o,
  input  logic [2:0]                        fan_sw_i,
  output logic                              fan_pwm_o,
  output logic                              rtc_clk_o,
  input  logic                              uart_rx_i
);

  logic                               sys_rst_n;
  logic [7:0]                         rx_byte;
  logic                               rx_valid;
  board_pkg::gpio_cmd_u               rx_cmd;
  board_pkg::gpio_pads_t              pads;
  logic                               status;
  logic [board_pkg::GPIO_COUNT-1:0]   gpio_masked;

  //////////////////////////////
  // Reset
  //////////////////////////////

  rst_sync i_rst_sync (
    .soc_clk ( soc_clk   ),
    .rst_n   ( rst_n     ),
    .rst_no  ( sys_rst_n )
  );

  //////////////////////////////
  // Clocks and fan
  //////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( sys_rst_n ),
    .rtc_clk_o ( rtc_clk_o )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( sys_rst_n ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  //////////////////////////////
  // Command path
  //////////////////////////////

  uart_rx i_uart_rx (
    .soc_clk ( soc_clk   ),
    .rst_n   ( sys_rst_n ),
    .rx_i    ( uart_rx_i ),
    .byte_o  ( rx_byte   ),
    .valid_o ( rx_valid  )
  );

  // Received byte as is, decoded inside the register block
  assign rx_cmd.raw = rx_byte;

  gpio_ctrl i_gpio_ctrl (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( sys_rst_n   ),
    .fetch_en_i  ( fetch_en_i  ),
    .cmd_i       ( rx_cmd      ),
    .cmd_valid_i ( rx_valid    ),
    .gpio_in_i   ( gpio_masked ),
    .pads_o      ( pads        ),
    .status_o    ( status      )
  );

  assign status_o = status;

  //////////////////////////////
  // Pad gating
  //////////////////////////////

  for (genvar i = 0; i < board_pkg::GPIO_COUNT; i++) begin : g_pad
    assign gpio_o[i]      = pads.out_en[i] ? pads.out[i] : 1'b0;
    // A driving pin reads as 0
    assign gpio_masked[i] = pads.out_en[i] ? 1'b0 : gpio_i[i];
  end

endmodule

/* dv/board_top_assert.sv */
// Concurrent checks on the board top level, bound into board_top.
// Covers reset values, GPIO and status stability between accepted
// commands, the RTC half period and the fan PWM duty per period.

`timescale 1ns/1ps

module board_top_assert (
  input logic                             soc_clk,
  input logic                             rst_n,
  input logic                             fetch_en_i,
  input logic                             rx_valid_i,
  input logic [board_pkg::GPIO_COUNT-1:0] gpio_out_i,
  input logic                             status_i,
  input logic [2:0]                       fan_sw_i,
  input logic                             fan_pwm_i,
  input logic                             rtc_clk_i
);

  localparam logic [15:0] RTC_HALF   = board_pkg::RTC_DIV_LAST + 16'd1;
  localparam int unsigned PWM_PERIOD = 2 ** board_pkg::PWM_PERIOD_BITS;

  int unsigned fail_cnt = 0;

  logic                  rtc_prev;
  logic [15:0]           rtc_run;
  logic [2:0]            sw_prev;
  logic [4:0]            sw_run;
  logic [4:0]            up_cnt;
  logic [PWM_PERIOD-1:0] pwm_hist;

  // Run lengths and the last PWM_PERIOD output samples
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_prev <= 1'b0;
      rtc_run  <= '0;
      sw_prev  <= '0;
      sw_run   <= '0;
      up_cnt   <= '0;
      pwm_hist <= '0;
    end else begin
      rtc_prev <= rtc_clk_i;
      rtc_run  <= (rtc_clk_i != rtc_prev) ? 16'd1 : rtc_run + 16'd1;
      sw_prev  <= fan_sw_i;
      sw_run   <= (fan_sw_i != sw_prev) ? 5'd1 : ((sw_run == 5'd31) ? sw_run : sw_run + 5'd1);
      up_cnt   <= (up_cnt == 5'd31) ? up_cnt : up_cnt + 5'd1;
      pwm_hist <= {pwm_hist[PWM_PERIOD-2:0], fan_pwm_i};
    end
  end

  reset_values: assert property (@(posedge soc_clk)
    $rose(rst_n) |-> (gpio_out_i == '0) && !status_i && !fan_pwm_i && !rtc_clk_i)
    else begin
      $error("Outputs not cleared on the first cycle after reset");
      fail_cnt++;
    end

  gpio_stable: assert property (@(posedge soc_clk) disable iff (!rst_n)
    $changed(gpio_out_i) |-> $past(rx_valid_i && fetch_en_i))
    else begin
      $error("gpio_o changed without an accepted command byte");
      fail_cnt++;
    end

  status_stable: assert property (@(posedge soc_clk) disable iff (!rst_n)
    $changed(status_i) |-> $past(rx_valid_i && fetch_en_i))
    else begin
      $error("status_o changed without an accepted command byte");
      fail_cnt++;
    end

  rtc_interval: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (rtc_clk_i != rtc_prev) |-> (rtc_run == RTC_HALF))
    else begin
      $error("rtc_clk_o toggled after %0d stable cycles", rtc_run);
      fail_cnt++;
    end

  rtc_max_run: assert property (@(posedge soc_clk) disable iff (!rst_n)
    rtc_run <= RTC_HALF)
    else begin
      $error("rtc_clk_o held longer than one half period");
      fail_cnt++;
    end

  // Window only counts once the switch value is settled for a whole period
  fan_duty: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (sw_run > 5'd16 && up_cnt > 5'd16) |-> ($countones(pwm_hist) == 2 * int'(sw_prev)))
    else begin
      $error("fan_pwm_o duty wrong for switch setting %0d", sw_prev);
      fail_cnt++;
    end

endmodule

bind board_top board_top_assert u_assert (
  .soc_clk    ( soc_clk    ),
  .rst_n      ( sys_rst_n  ),
  .fetch_en_i ( fetch_en_i ),
  .rx_valid_i ( rx_valid   ),
  .gpio_out_i ( gpio_o     ),
  .status_i   ( status_o   ),
  .fan_sw_i   ( fan_sw_i   ),
  .fan_pwm_i  ( fan_pwm_o  ),
  .rtc_clk_i  ( rtc_clk_o  )
);

/* dv/tb_board_top.sv */
// Testbench for the GPIO board wrapper.
// Sends UART command frames into board_top and keeps its own copy of the
// GPIO registers to compare gpio_o and status_o after every frame.
// Fan switches are swept in parallel. The bound assertion module checks
// reset values, register stability, the RTC half period and the PWM duty.

`timescale 1ns/1ps

module tb_board_top;

  localparam int unsigned CLK_PERIOD     = 100;
  localparam int unsigned FAN_HOLD       = 40;
  localparam int unsigned RTC_HALF       = int'(board_pkg::RTC_DIV_LAST) + 1;
  localparam int unsigned TIMEOUT_CYCLES = 12 * 10 * board_pkg::CLKS_PER_BIT
                                         + 4 * RTC_HALF + 500;

  logic                             soc_clk;
  logic                             rst_n;
  logic                             fetch_en_i;
  logic [board_pkg::GPIO_COUNT-1:0] gpio_i;
  logic [board_pkg::GPIO_COUNT-1:0] gpio_o;
  logic                             status_o;
  logic [2:0]                       fan_sw_i;
  logic                             fan_pwm_o;
  logic                             rtc_clk_o;
  logic                             uart_rx_i;

  // Expected register contents
  logic [board_pkg::GPIO_COUNT-1:0] exp_out;
  logic [board_pkg::GPIO_COUNT-1:0] exp_en;
  logic                             exp_status;

  int unsigned err_cnt     = 0;
  int unsigned cycle_cnt   = 0;
  int unsigned rtc_toggles = 0;
  logic        rtc_seen    = 1'b0;

  board_top uut (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .fetch_en_i ( fetch_en_i ),
    .gpio_i     ( gpio_i     ),
    .gpio_o     ( gpio_o     ),
    .status_o   ( status_o   ),
    .fan_sw_i   ( fan_sw_i   ),
    .fan_pwm_o  ( fan_pwm_o  ),
    .rtc_clk_o  ( rtc_clk_o  ),
    .uart_rx_i  ( uart_rx_i  )
  );

  always #(CLK_PERIOD / 2) soc_clk = ~soc_clk;

  //////////////////////////////
  // Run limit and RTC monitor
  //////////////////////////////

  always @(posedge soc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: test did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  always @(posedge soc_clk) begin
    if (rtc_clk_o !== rtc_seen) begin
      rtc_toggles <= rtc_toggles + 1;
    end
    rtc_seen <= rtc_clk_o;
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // 8N1 frame, LSB first, one bit per CLKS_PER_BIT cycles
  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i = frame[i];
      repeat (board_pkg::CLKS_PER_BIT) @(negedge soc_clk);
    end
  endtask

  task automatic compare_outputs(input string what);
    logic [board_pkg::GPIO_COUNT-1:0] exp_gpio;
    exp_gpio = exp_out & exp_en;
    if (gpio_o !== exp_gpio) begin
      $display("[FAIL] %0t ns: %s: gpio_o is %h, expected %h", $time, what, gpio_o, exp_gpio);
      err_cnt++;
    end
    if (status_o !== exp_status) begin
      $display("[FAIL] %0t ns: %s: status_o is %b, expected %b",
               $time, what, status_o, exp_status);
      err_cnt++;
    end
  endtask

  // Sends one command, updates the expected registers, then compares.
  // Registers settle two cycles after the stop-bit midpoint, before the frame ends
  task automatic send_cmd(input logic [1:0] op, input logic [3:0] data, input string what);
    board_pkg::gpio_cmd_u cmd;
    cmd.fields.op   = op;
    cmd.fields.rsvd = 2'b00;
    cmd.fields.data = data;
    uart_send(cmd.raw);
    if (fetch_en_i) begin
      case (op)
        2'd0:    exp_out = data;
        2'd1:    exp_en = data;
        2'd2:    exp_status = data[0];
        default: exp_out = gpio_i & ~exp_en;
      endcase
    end
    compare_outputs(what);
    repeat (2) @(negedge soc_clk);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [3:0]  rnd;
    int unsigned total_errs;
    void'($urandom(32'h4298ca1a));
    soc_clk    = 1'b0;
    rst_n      = 1'b0;
    fetch_en_i = 1'b0;
    gpio_i     = '0;
    fan_sw_i   = 3'd0;
    uart_rx_i  = 1'b1;
    exp_out    = '0;
    exp_en     = '0;
    exp_status = 1'b0;
    repeat (2) @(negedge soc_clk);
    rst_n = 1'b1;
    repeat (4) @(negedge soc_clk);
    compare_outputs("after reset");

    fork
      begin
        fetch_en_i = 1'b1;
        send_cmd(board_pkg::OP_WR_EN, 4'hF, "enable all pins");
        rnd = 4'($urandom());
        send_cmd(board_pkg::OP_WR_OUT, rnd, "random output write");
        send_cmd(board_pkg::OP_SET_STATUS, 4'h1, "status set");

        // Bytes without fetch enable are dropped
        // All pins still drive, so any taken byte shows up at gpio_o
        fetch_en_i = 1'b0;
        send_cmd(board_pkg::OP_WR_OUT, ~exp_out, "output write while fetch off");
        send_cmd(board_pkg::OP_SET_STATUS, 4'h0, "status clear while fetch off");

        fetch_en_i = 1'b1;
        rnd = 4'($urandom());
        send_cmd(board_pkg::OP_WR_EN, rnd, "random enable write");

        // Latch inputs with the two upper pins not driving
        send_cmd(board_pkg::OP_WR_EN, 4'b0011, "lower pins driving");
        // Driving pads see 1, the others differ from the old output
        gpio_i = {~exp_out[3:2], 2'b11};
        rnd    = 4'($urandom());
        send_cmd(board_pkg::OP_LATCH_IN, rnd, "input latch");
        send_cmd(board_pkg::OP_WR_EN, 4'hF, "latched value on all pins");
        send_cmd(board_pkg::OP_SET_STATUS, 4'h0, "status clear");

        rnd = 4'($urandom());
        send_cmd(board_pkg::OP_WR_EN, rnd, "final enable write");
        rnd = 4'($urandom());
        send_cmd(board_pkg::OP_WR_OUT, rnd, "final output write");
      end
      begin
        // Each setting held for more than two PWM periods
        for (int sw = 0; sw < 8; sw++) begin
          fan_sw_i = 3'(sw);
          repeat (FAN_HOLD) @(negedge soc_clk);
        end
      end
    join

    // At least three RTC edges so the interval check sees full half periods
    while (rtc_toggles < 3) begin
      @(negedge soc_clk);
    end

    total_errs = err_cnt + uut.u_assert.fail_cnt;
    $display("Summary: %0d value errors, %0d assertion errors",
             err_cnt, uut.u_assert.fail_cnt);
    if (total_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/board_pkg.sv
verilog/rst_sync.sv
verilog/rtc_divider.sv
verilog/fan_pwm.sv
verilog/uart_rx.sv
verilog/gpio_ctrl.sv
verilog/board_top.sv
dv/board_top_assert.sv
dv/tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the board_top regression with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_board_top \
  -f files.f \
  -o tb_board_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

# Let every assertion failure be counted instead of stopping at the first one
./obj_dir/tb_board_top +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Regression passed$" "$SIM_LOG"; then
  exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1
